//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // major opcodes, encoded as instr[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD    = 5'b00000,
    OPC_OP_IMM  = 5'b00100,
    OPC_AUIPC   = 5'b00101,
    OPC_STORE   = 5'b01000,
    OPC_OP      = 5'b01100,
    OPC_LUI     = 5'b01101,
    OPC_BRANCH  = 5'b11000,
    OPC_JALR    = 5'b11001,
    OPC_JAL     = 5'b11011,
    OPC_SYSTEM  = 5'b11100,
    OPC_ILLEGAL = 5'b11111  // no-op in exec
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_funct_e;

  typedef enum logic [2:0] {
    SYS_NONE, SYS_CSRRW, SYS_CSRRS, SYS_CSRRC, SYS_ECALL, SYS_MRET
  } sys_op_e;

  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;

  localparam logic [31:0] CAUSE_ECALL_M = 32'd11;

  // access size, same coding as funct3[1:0] of loads and stores
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  typedef struct packed {
    opcode_e     op;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    alu_op_e     alu_op;
    logic        sel_a_pc;   // operand a is the pc
    logic        sel_b_imm;  // operand b is the immediate
    sys_op_e     sys_op;
    logic [11:0] csr_addr;
    logic        rd_wen;
  } decoded_instr_t;

  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] wdata;
    logic        we;
    logic [1:0]  size;
    logic        unsigned_ld;
  } bus_req_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_m2s_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

  typedef struct packed {
    logic        en;
    logic [11:0] addr;
    logic [31:0] data;
  } csr_wr_t;

endpackage

`default_nettype wire

//--- decode/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder
  import rv_pkg::*;
(
  input  logic [31:0]    instr,
  output decoded_instr_t dec
);

  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // shared by OP and OP_IMM, alt picks SUB / SRA
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec           = '0;
    dec.op        = OPC_ILLEGAL;
    dec.funct3    = instr[14:12];
    dec.rd        = instr[11:7];
    dec.rs1       = instr[19:15];
    dec.rs2       = instr[24:20];
    dec.csr_addr  = instr[31:20];
    dec.imm       = imm_i;
    dec.alu_op    = ALU_ADD;
    dec.sys_op    = SYS_NONE;

    if (instr[1:0] == 2'b11) begin
      case (instr[6:2])
        OPC_LUI: begin
          dec.op        = OPC_LUI;
          dec.imm       = imm_u;
          dec.alu_op    = ALU_PASS_B;
          dec.sel_b_imm = 1'b1;
          dec.rd_wen    = 1'b1;
        end
        OPC_AUIPC: begin
          dec.op        = OPC_AUIPC;
          dec.imm       = imm_u;
          dec.sel_a_pc  = 1'b1;
          dec.sel_b_imm = 1'b1;
          dec.rd_wen    = 1'b1;
        end
        OPC_JAL: begin
          dec.op     = OPC_JAL;
          dec.imm    = imm_j;
          dec.rd_wen = 1'b1;
        end
        OPC_JALR: begin
          dec.op        = OPC_JALR;
          dec.sel_b_imm = 1'b1;
          dec.rd_wen    = 1'b1;
        end
        OPC_BRANCH: begin
          dec.imm = imm_b;
          case (instr[14:13])
            2'b00: begin dec.op = OPC_BRANCH; dec.alu_op = ALU_SUB;  end // eq / ne
            2'b10: begin dec.op = OPC_BRANCH; dec.alu_op = ALU_SLT;  end
            2'b11: begin dec.op = OPC_BRANCH; dec.alu_op = ALU_SLTU; end
            default: ;
          endcase
        end
        OPC_LOAD: begin
          dec.sel_b_imm = 1'b1;
          if (instr[13:12] != 2'b11 && instr[14:12] != 3'b110) begin
            dec.op     = OPC_LOAD;
            dec.rd_wen = 1'b1;
          end
        end
        OPC_STORE: begin
          dec.imm       = imm_s;
          dec.sel_b_imm = 1'b1;
          if (!instr[14] && instr[13:12] != 2'b11) dec.op = OPC_STORE;
        end
        OPC_OP_IMM: begin
          dec.op        = OPC_OP_IMM;
          dec.alu_op    = arith_op(instr[14:12], instr[30] && instr[14:12] == 3'b101);
          dec.sel_b_imm = 1'b1;
          dec.rd_wen    = 1'b1;
        end
        OPC_OP: begin
          dec.op     = OPC_OP;
          dec.alu_op = arith_op(instr[14:12], instr[30]);
          dec.rd_wen = 1'b1;
        end
        OPC_SYSTEM: begin
          case (instr[14:12])
            3'b001: dec.sys_op = SYS_CSRRW;
            3'b010: dec.sys_op = SYS_CSRRS;
            3'b011: dec.sys_op = SYS_CSRRC;
            3'b000: begin
              if (instr[31:20] == 12'h000)      dec.sys_op = SYS_ECALL;
              else if (instr[31:20] == 12'h302) dec.sys_op = SYS_MRET;
            end
            default: ; // immediate csr forms not supported
          endcase
          if (dec.sys_op != SYS_NONE) dec.op = OPC_SYSTEM;
          dec.rd_wen = (instr[14:12] != 3'b000) && (dec.sys_op != SYS_NONE);
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- exec/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
  import rv_pkg::*;
(
  input  alu_op_e     op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] res
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // only the low five bits count

  always_comb begin
    case (op)
      ALU_ADD:    res = a + b;
      ALU_SUB:    res = a - b; // zero test for beq / bne
      ALU_SLL:    res = a << shamt;
      ALU_SLT:    res = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   res = {31'b0, a < b};
      ALU_XOR:    res = a ^ b;
      ALU_SRL:    res = a >> shamt;
      ALU_SRA:    res = $unsigned($signed(a) >>> shamt);
      ALU_OR:     res = a | b;
      ALU_AND:    res = a & b;
      ALU_PASS_B: res = b; // lui
      default:    res = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- exec/exec_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module exec_ctrl
  import rv_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic           clk,
  input  logic           rst,
  input  decoded_instr_t dec,
  output logic [31:0]    instr,
  input  logic [31:0]    rs1_data,
  input  logic [31:0]    rs2_data,
  output alu_op_e        alu_op,
  output logic [31:0]    alu_a,
  output logic [31:0]    alu_b,
  input  logic [31:0]    alu_res,
  output logic           rd_we,
  output logic [4:0]     rd_addr,
  output logic [31:0]    rd_data,
  output logic [11:0]    csr_rd_addr,
  input  logic [31:0]    csr_rdata,
  output csr_wr_t        csr_wr1,
  output csr_wr_t        csr_wr2,
  input  logic [31:0]    mtvec,
  input  logic [31:0]    mepc,
  output bus_req_t       req,
  output logic           req_valid,
  input  logic           done,
  input  logic [31:0]    rdata
);

  typedef enum logic [1:0] {FETCH, EXEC, MEM} state_e;

  state_e      state;
  logic [31:0] pc;
  logic [31:0] ir;
  logic [31:0] pc_plus4, pc_rel, next_pc;
  logic [31:0] csr_new;
  logic        is_mem, is_csr, is_ecall, taken;

  assign instr    = ir;
  assign pc_plus4 = pc + 32'd4;
  assign pc_rel   = pc + dec.imm; // jal and taken branches
  assign is_mem   = (dec.op == OPC_LOAD) || (dec.op == OPC_STORE);
  assign is_ecall = (dec.op == OPC_SYSTEM) && (dec.sys_op == SYS_ECALL);
  assign is_csr   = (dec.op == OPC_SYSTEM) &&
                    (dec.sys_op inside {SYS_CSRRW, SYS_CSRRS, SYS_CSRRC});

  // operand muxes
  assign alu_op = dec.alu_op;
  assign alu_a  = dec.sel_a_pc ? pc : rs1_data;
  assign alu_b  = dec.sel_b_imm ? dec.imm : rs2_data;

  always_comb begin
    case (br_funct_e'(dec.funct3))
      BR_BEQ:          taken = (alu_res == 32'b0);
      BR_BNE:          taken = (alu_res != 32'b0);
      BR_BLT, BR_BLTU: taken = alu_res[0];
      default:         taken = !alu_res[0]; // bge, bgeu
    endcase
  end

  always_comb begin
    next_pc = pc_plus4;
    case (dec.op)
      OPC_JAL:    next_pc = pc_rel;
      OPC_JALR:   next_pc = {alu_res[31:1], 1'b0};
      OPC_BRANCH: next_pc = taken ? pc_rel : pc_plus4;
      OPC_SYSTEM: begin
        if (dec.sys_op == SYS_ECALL)     next_pc = mtvec;
        else if (dec.sys_op == SYS_MRET) next_pc = mepc;
      end
      default: ;
    endcase
  end

  // register write back
  always_comb begin
    rd_addr = dec.rd;
    if (state == MEM) begin
      rd_we   = done && (dec.op == OPC_LOAD);
      rd_data = rdata;
    end else begin
      rd_we   = (state == EXEC) && dec.rd_wen && !is_mem;
      rd_data = alu_res;
      if (dec.op == OPC_JAL || dec.op == OPC_JALR) rd_data = pc_plus4; // link
      else if (dec.op == OPC_SYSTEM)               rd_data = csr_rdata; // old csr value
    end
  end

  assign csr_rd_addr = dec.csr_addr;

  always_comb begin
    case (dec.sys_op)
      SYS_CSRRS: csr_new = csr_rdata | rs1_data;
      SYS_CSRRC: csr_new = csr_rdata & ~rs1_data;
      default:   csr_new = rs1_data;
    endcase
  end

  // ecall reuses port 1 for mepc, port 2 takes mcause
  assign csr_wr1 = '{en:   (state == EXEC) && (is_csr || is_ecall),
                     addr: is_ecall ? CSR_MEPC : dec.csr_addr,
                     data: is_ecall ? pc : csr_new};
  assign csr_wr2 = '{en: (state == EXEC) && is_ecall, addr: CSR_MCAUSE, data: CAUSE_ECALL_M};

  always_comb begin
    req_valid = (state == FETCH) || (state == MEM);
    if (state == MEM) begin
      req = '{adr: alu_res, wdata: rs2_data, we: dec.op == OPC_STORE,
              size: dec.funct3[1:0], unsigned_ld: dec.funct3[2]};
    end else begin
      req = '{adr: pc, wdata: 32'b0, we: 1'b0, size: SIZE_WORD, unsigned_ld: 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FETCH;
      pc    <= RESET_PC;
    end else begin
      case (state)
        FETCH: if (done) state <= EXEC;
        EXEC: begin
          if (is_mem) begin
            state <= MEM;
          end else begin
            state <= FETCH;
            pc    <= next_pc;
          end
        end
        MEM: begin
          if (done) begin
            state <= FETCH;
            pc    <= pc_plus4;
          end
        end
        default: state <= FETCH;
      endcase
    end
  end

  // instruction word latched on the fetch ack
  always_ff @(posedge clk) begin
    if (state == FETCH && done) ir <= rdata;
  end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        we,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data
);

  logic [31:0] regs [NUM_REGS];
  logic        rs1_ok, rs2_ok, wr_ok;

  // x0 and registers past NUM_REGS are not backed
  assign rs1_ok = (rs1_addr != 5'd0) && (int'(rs1_addr) < NUM_REGS);
  assign rs2_ok = (rs2_addr != 5'd0) && (int'(rs2_addr) < NUM_REGS);
  assign wr_ok  = (wr_addr != 5'd0) && (int'(wr_addr) < NUM_REGS);

  assign rs1_data = rs1_ok ? regs[rs1_addr] : 32'b0;
  assign rs2_data = rs2_ok ? regs[rs2_addr] : 32'b0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= 32'b0;
      end
    end else if (we && wr_ok) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file
  import rv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [11:0] rd_addr,
  output logic [31:0] rdata,
  input  csr_wr_t     wr1,
  input  csr_wr_t     wr2,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);

  logic [31:0] mtvec_q, mepc_q, mcause_q, mscratch_q;
  csr_wr_t     wr_port [2];

  assign wr_port[0] = wr1;
  assign wr_port[1] = wr2; // applied last, wins on same address

  assign mtvec = mtvec_q;
  assign mepc  = mepc_q;

  always_comb begin
    case (rd_addr)
      CSR_MTVEC:    rdata = mtvec_q;
      CSR_MEPC:     rdata = mepc_q;
      CSR_MCAUSE:   rdata = mcause_q;
      CSR_MSCRATCH: rdata = mscratch_q;
      default:      rdata = 32'b0; // unimplemented
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec_q    <= 32'b0;
      mepc_q     <= 32'b0;
      mcause_q   <= 32'b0;
      mscratch_q <= 32'b0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (wr_port[i].en) begin
          case (wr_port[i].addr)
            CSR_MTVEC:    mtvec_q    <= wr_port[i].data;
            CSR_MEPC:     mepc_q     <= wr_port[i].data;
            CSR_MCAUSE:   mcause_q   <= wr_port[i].data;
            CSR_MSCRATCH: mscratch_q <= wr_port[i].data;
            default: ;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/bus_master.sv
`timescale 1ns/1ns
`default_nettype none

module bus_master
  import rv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  bus_req_t    req,
  input  logic        req_valid,
  output logic        done,
  output logic [31:0] rdata,
  output wb_m2s_t     wb_o,
  input  wb_s2m_t     wb_i
);

  logic        busy;
  bus_req_t    req_q;
  logic [3:0]  sel;
  logic [31:0] wdat;
  logic [31:0] rshift;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (!busy && req_valid) begin
      busy <= 1'b1;
    end else if (busy && wb_i.ack) begin
      busy <= 1'b0; // classic cycle ends on ack
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && req_valid) req_q <= req;
  end

  // byte lanes from size and low address bits
  always_comb begin
    case (req_q.size)
      SIZE_BYTE: begin
        sel  = 4'b0001 << req_q.adr[1:0];
        wdat = {4{req_q.wdata[7:0]}};
      end
      SIZE_HALF: begin
        sel  = req_q.adr[1] ? 4'b1100 : 4'b0011;
        wdat = {2{req_q.wdata[15:0]}};
      end
      default: begin
        sel  = 4'b1111;
        wdat = req_q.wdata;
      end
    endcase
  end

  assign wb_o = '{cyc: busy, stb: busy, we: busy && req_q.we,
                  adr: req_q.adr, dat: wdat, sel: sel};

  assign done   = busy && wb_i.ack;
  assign rshift = wb_i.dat >> {req_q.adr[1:0], 3'b000};

  always_comb begin
    case (req_q.size)
      SIZE_BYTE: rdata = {{24{rshift[7] && !req_q.unsigned_ld}}, rshift[7:0]};
      SIZE_HALF: rdata = {{16{rshift[15] && !req_q.unsigned_ld}}, rshift[15:0]};
      default:   rdata = wb_i.dat;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top
  import rv_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0,
  parameter int          NUM_REGS = 32
) (
  input  logic    clk,
  input  logic    rst,
  output wb_m2s_t wb_o,
  input  wb_s2m_t wb_i
);

  decoded_instr_t dec;
  logic [31:0]    instr;
  logic [31:0]    rs1_data, rs2_data;
  alu_op_e        alu_op;
  logic [31:0]    alu_a, alu_b, alu_res;
  logic           rd_we;
  logic [4:0]     rd_addr;
  logic [31:0]    rd_data;
  logic [11:0]    csr_rd_addr;
  logic [31:0]    csr_rdata, mtvec, mepc;
  csr_wr_t        csr_wr1, csr_wr2;
  bus_req_t       req;
  logic           req_valid, done;
  logic [31:0]    rdata;

  exec_ctrl #(.RESET_PC(RESET_PC)) exec_ctrl_i (
    .clk, .rst, .dec, .instr, .rs1_data, .rs2_data,
    .alu_op, .alu_a, .alu_b, .alu_res,
    .rd_we, .rd_addr, .rd_data,
    .csr_rd_addr, .csr_rdata, .csr_wr1, .csr_wr2, .mtvec, .mepc,
    .req, .req_valid, .done, .rdata
  );

  instr_decoder instr_decoder_i (.instr, .dec);

  alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .res(alu_res));

  reg_file #(.NUM_REGS(NUM_REGS)) reg_file_i (
    .clk, .rst,
    .rs1_addr(dec.rs1), .rs2_addr(dec.rs2),
    .rs1_data, .rs2_data,
    .we(rd_we), .wr_addr(rd_addr), .wr_data(rd_data)
  );

  csr_file csr_file_i (
    .clk, .rst, .rd_addr(csr_rd_addr), .rdata(csr_rdata),
    .wr1(csr_wr1), .wr2(csr_wr2), .mtvec, .mepc
  );

  bus_master bus_master_i (
    .clk, .rst, .req, .req_valid, .done, .rdata, .wb_o, .wb_i
  );

endmodule

`default_nettype wire

//--- test/tb_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem
  import rv_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wb_m2s_t m2s,
  output wb_s2m_t s2m
);

  logic [31:0] mem [128]; // 512 bytes, word addressed by adr[8:2]
  logic        ack_q = 1'b0;
  logic [31:0] dat_q = 32'b0;
  logic        active;
  logic [1:0]  wait_cnt;
  wb_m2s_t     store_log [$];
  logic        end_hit = 1'b0; // store to 0x1fc seen

  assign s2m = '{ack: ack_q, dat: dat_q};

  // fill then copy the program from address 0, clears the store log
  task automatic load_program(input logic [31:0] words [$]);
    logic [31:0] addr;
    for (int i = 0; i < 128; i++) begin
      addr   = i * 4;
      mem[i] = {~addr[15:0], addr[15:0]};
    end
    foreach (words[i]) mem[i] = words[i];
    store_log.delete();
    end_hit = 1'b0;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      ack_q  <= 1'b0;
      active <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      if (m2s.cyc && m2s.stb && !ack_q) begin
        if (!active) begin
          active   <= 1'b1;
          wait_cnt <= 2'($urandom_range(0, 3)); // random wait states
        end else if (wait_cnt == 2'd0) begin
          ack_q  <= 1'b1;
          active <= 1'b0;
          dat_q  <= mem[m2s.adr[8:2]];
          if (m2s.we) begin
            for (int b = 0; b < 4; b++) begin
              if (m2s.sel[b]) mem[m2s.adr[8:2]][8*b +: 8] <= m2s.dat[8*b +: 8];
            end
            store_log.push_back(m2s);
            if (m2s.adr == 32'h1fc) end_hit <= 1'b1;
          end
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core
  import rv_pkg::*;
;

  localparam logic [31:0] RESET_PC     = 32'h0;
  localparam int          CYCLE_LIMIT  = 5000;
  localparam logic [6:0]  OPCODE_LOAD  = 7'h03;
  localparam logic [6:0]  OPCODE_IMM   = 7'h13;
  localparam logic [6:0]  OPCODE_LUI   = 7'h37;
  localparam logic [6:0]  OPCODE_JALR  = 7'h67;
  localparam logic [6:0]  OPCODE_SYS   = 7'h73;
  localparam logic [31:0] NOP          = 32'h00000013;

  logic        clk;
  logic        rst;
  wb_m2s_t     wb_o;
  wb_s2m_t     wb_i;
  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] prog [$];
  wb_m2s_t     expected [$];
  logic [31:0] slot; // next result address

  core_top #(.RESET_PC(RESET_PC), .NUM_REGS(32)) dut_i (
    .clk, .rst, .wb_o, .wb_i
  );

  tb_mem mem_i (.clk, .rst, .m2s(wb_o), .s2m(wb_i));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit, counts every cycle of all tests
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // expected values by the rv32i rules
  function automatic logic [31:0] rv_alu(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  task automatic check_word(input logic [31:0] act, input logic [31:0] exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR at %0t: %s: got %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_bus(input wb_m2s_t act, input wb_m2s_t exp, input string what);
    checks++;
    if (act.we !== exp.we || act.adr !== exp.adr || act.sel !== exp.sel) begin
      errors++;
      $display("ERROR at %0t: %s: got we %b adr %h sel %b, expected we %b adr %h sel %b",
               $time, what, act.we, act.adr, act.sel, exp.we, exp.adr, exp.sel);
    end
  endtask

  task automatic begin_program();
    prog.delete();
    expected.delete();
    slot = 32'h100;
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  function automatic logic [31:0] pc_now();
    return prog.size() * 4;
  endfunction

  task automatic load_imm(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] hi;
    hi = (val + 32'h800) >> 12; // addi sign extends the low part
    emit({hi[19:0], rd, OPCODE_LUI});
    emit(enc_i(val[11:0], rd, 3'd0, rd, OPCODE_IMM));
  endtask

  task automatic expect_store(input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat);
    expected.push_back('{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat, sel: sel});
  endtask

  task automatic put_result(input logic [4:0] rs, input logic [31:0] exp);
    emit(enc_s(slot[11:0], rs, 5'd0, 3'd2));
    expect_store(slot, 4'hf, exp);
    slot += 4;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    @(negedge clk);
    mem_i.load_program(prog);
    for (int i = 0; i < 4; i++) begin
      check_word({31'b0, wb_o.cyc | wb_o.stb}, 32'b0, "cyc/stb during reset");
      @(negedge clk);
    end
    check_word({31'b0, wb_o.cyc | wb_o.stb}, 32'b0, "cyc/stb at reset release");
    rst = 1'b0;
    @(negedge clk);
    if (!wb_o.cyc) begin
      errors++;
      $display("no bus cycle started one cycle after reset");
    end else begin
      check_bus(wb_o, '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: RESET_PC, dat: 32'b0, sel: 4'hf},
                "first fetch");
    end
  endtask

  // runs until the end marker store, then checks the logged stores in order
  task automatic run_program(input string name);
    wb_m2s_t st;
    int      k;
    emit(enc_s(12'h1fc, 5'd0, 5'd0, 3'd2));
    emit(enc_j(21'd0, 5'd0));
    apply_reset();
    while (!mem_i.end_hit) @(negedge clk);
    k = 0;
    foreach (mem_i.store_log[i]) begin
      st = mem_i.store_log[i];
      if (st.adr != 32'h1fc) begin
        if (k >= expected.size()) begin
          errors++;
          $display("%s: unexpected extra store to %h", name, st.adr);
        end else begin
          check_bus(st, expected[k], {name, " store"});
          check_word(st.dat & lane_mask(st.sel),
                     expected[k].dat & lane_mask(expected[k].sel), {name, " store data"});
        end
        k++;
      end
    end
    if (k < expected.size()) begin
      errors++;
      $display("%s: only %0d of %0d stores were seen", name, k, expected.size());
    end
  endtask

  task automatic test_alu();
    logic [31:0] a, b, imm;
    a = $urandom;
    b = $urandom;
    begin_program();
    load_imm(5'd1, a);
    load_imm(5'd2, b);
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
      put_result(5'd3, rv_alu(3'(f), 1'b0, a, b));
    end
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3)); // sub
    put_result(5'd3, rv_alu(3'd0, 1'b1, a, b));
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3)); // sra
    put_result(5'd3, rv_alu(3'd5, 1'b1, a, b));
    for (int f = 0; f < 8; f++) begin
      imm = {{20{1'b0}}, 12'($urandom)};
      if (f == 1 || f == 5) imm[11:5] = 7'h00;
      emit(enc_i(imm[11:0], 5'd1, 3'(f), 5'd3, OPCODE_IMM));
      put_result(5'd3, rv_alu(3'(f), 1'b0, a, {{20{imm[11]}}, imm[11:0]}));
    end
    imm = 32'($urandom_range(0, 31));
    emit(enc_i({7'h20, imm[4:0]}, 5'd1, 3'd5, 5'd3, OPCODE_IMM)); // srai
    put_result(5'd3, rv_alu(3'd5, 1'b1, a, imm));
    run_program("alu");
  endtask

  task automatic branch_setup(input logic [31:0] a, input logic [31:0] b);
    begin_program();
    load_imm(5'd1, a);
    load_imm(5'd2, a);
    load_imm(5'd4, a);
    load_imm(5'd5, b);
  endtask

  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [31:0] va, input logic [31:0] vb);
    emit(enc_i(12'd1, 5'd0, 3'd0, 5'd3, OPCODE_IMM));
    emit(enc_b(13'd8, rs2, rs1, f3));
    emit(enc_i(12'd1, 5'd3, 3'd0, 5'd3, OPCODE_IMM)); // fall through makes it 2
    put_result(5'd3, branch_taken(f3, va, vb) ? 32'd1 : 32'd2);
  endtask

  task automatic test_control();
    logic [31:0] a, b, t, p;
    logic [2:0]  codes [6];
    codes = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    a = $urandom;
    b = $urandom;
    if (a == b) b = a + 1;
    if ($signed(a) > $signed(b)) begin
      t = a;
      a = b;
      b = t;
    end
    for (int i = 0; i < 6; i++) begin
      if (i == 0 || i == 3) branch_setup(a, b);
      branch_case(codes[i], 5'd1, 5'd2, a, a);
      branch_case(codes[i], 5'd4, 5'd5, a, b);
      branch_case(codes[i], 5'd5, 5'd4, b, a);
      if (i == 2) run_program("branch signed");
    end
    p = pc_now();
    emit(enc_j(21'd8, 5'd10));
    emit(enc_i(12'd0, 5'd0, 3'd0, 5'd10, OPCODE_IMM)); // clears the link if not skipped
    put_result(5'd10, p + 4);
    p = pc_now();
    t = p + 9; // odd target, bit 0 is dropped
    emit(enc_i(t[11:0], 5'd0, 3'd0, 5'd12, OPCODE_JALR));
    emit(enc_i(12'd0, 5'd0, 3'd0, 5'd12, OPCODE_IMM));
    put_result(5'd12, p + 4);
    run_program("branch unsigned and jumps");
  endtask

  task automatic test_memory();
    logic [31:0] v1, v2, w0, w1;
    v1 = $urandom | 32'h0000_0080;
    v2 = $urandom | 32'h0000_8000;
    begin_program();
    load_imm(5'd1, v1);
    load_imm(5'd2, v2);
    emit(enc_s(12'h1e0, 5'd1, 5'd0, 3'd2));
    expect_store(32'h1e0, 4'b1111, v1);
    w0 = v1;
    emit(enc_s(12'h1e4, 5'd2, 5'd0, 3'd2));
    expect_store(32'h1e4, 4'b1111, v2);
    w1 = v2;
    emit(enc_s(12'h1e2, 5'd2, 5'd0, 3'd1));
    expect_store(32'h1e2, 4'b1100, {v2[15:0], 16'h0});
    w0[31:16] = v2[15:0];
    emit(enc_s(12'h1e5, 5'd1, 5'd0, 3'd0));
    expect_store(32'h1e5, 4'b0010, {16'h0, v1[7:0], 8'h0});
    w1[15:8] = v1[7:0];
    emit(enc_s(12'h1e7, 5'd2, 5'd0, 3'd0));
    expect_store(32'h1e7, 4'b1000, {v2[7:0], 24'h0});
    w1[31:24] = v2[7:0];
    emit(enc_i(12'h1e0, 5'd0, 3'd2, 5'd3, OPCODE_LOAD)); // lw
    put_result(5'd3, w0);
    emit(enc_i(12'h1e2, 5'd0, 3'd1, 5'd4, OPCODE_LOAD)); // lh
    put_result(5'd4, {{16{w0[31]}}, w0[31:16]});
    emit(enc_i(12'h1e2, 5'd0, 3'd5, 5'd5, OPCODE_LOAD)); // lhu
    put_result(5'd5, {16'h0, w0[31:16]});
    emit(enc_i(12'h1e5, 5'd0, 3'd0, 5'd6, OPCODE_LOAD)); // lb
    put_result(5'd6, {{24{w1[15]}}, w1[15:8]});
    emit(enc_i(12'h1e7, 5'd0, 3'd4, 5'd7, OPCODE_LOAD)); // lbu
    put_result(5'd7, {24'h0, w1[31:24]});
    emit(enc_i(12'h1e4, 5'd0, 3'd1, 5'd8, OPCODE_LOAD));
    put_result(5'd8, {{16{w1[15]}}, w1[15:0]});
    emit(enc_i(12'h1e0, 5'd0, 3'd0, 5'd9, OPCODE_LOAD));
    put_result(5'd9, {{24{w0[7]}}, w0[7:0]});
    emit(enc_i(12'h1e6, 5'd0, 3'd5, 5'd10, OPCODE_LOAD));
    put_result(5'd10, {16'h0, w1[31:16]});
    run_program("memory");
  endtask

  task automatic test_csr();
    logic [31:0] a, b, c, v;
    a = $urandom;
    b = $urandom;
    c = $urandom;
    begin_program();
    load_imm(5'd1, a);
    load_imm(5'd2, b);
    load_imm(5'd3, c);
    emit(enc_i(CSR_MSCRATCH, 5'd1, 3'd1, 5'd4, OPCODE_SYS)); // csrrw
    emit(enc_i(CSR_MSCRATCH, 5'd2, 3'd2, 5'd5, OPCODE_SYS)); // csrrs
    emit(enc_i(CSR_MSCRATCH, 5'd3, 3'd3, 5'd6, OPCODE_SYS)); // csrrc
    emit(enc_i(CSR_MSCRATCH, 5'd0, 3'd1, 5'd7, OPCODE_SYS));
    put_result(5'd4, 32'h0);
    v = a;
    put_result(5'd5, v);
    v = v | b;
    put_result(5'd6, v);
    v = v & ~c;
    put_result(5'd7, v);
    run_program("csr");
  endtask

  task automatic test_trap();
    logic [31:0] ecall_pc;
    ecall_pc = 32'h2c; // main at 0x20, after li and the mtvec write
    begin_program();
    emit(enc_j(21'h20, 5'd0));
    // handler at 0x4
    emit(enc_i(CSR_MEPC, 5'd0, 3'd2, 5'd7, OPCODE_SYS));
    put_result(5'd7, ecall_pc);
    emit(enc_i(CSR_MCAUSE, 5'd0, 3'd2, 5'd8, OPCODE_SYS));
    put_result(5'd8, 32'd11);
    emit(enc_i(12'd4, 5'd7, 3'd0, 5'd7, OPCODE_IMM));
    emit(enc_i(CSR_MEPC, 5'd7, 3'd1, 5'd0, OPCODE_SYS));
    emit(32'h30200073); // mret
    while (pc_now() < 32'h20) emit(NOP);
    load_imm(5'd1, 32'h4);
    emit(enc_i(CSR_MTVEC, 5'd1, 3'd1, 5'd0, OPCODE_SYS));
    emit(32'h00000073); // ecall
    emit(enc_i(12'h77, 5'd0, 3'd0, 5'd6, OPCODE_IMM));
    put_result(5'd6, 32'h77);
    run_program("ecall/mret");
  endtask

  task automatic test_reset();
    begin_program();
    emit(enc_i(12'h5a, 5'd0, 3'd0, 5'd1, OPCODE_IMM));
    put_result(5'd1, 32'h5a);
    run_program("reset");
  endtask

  initial begin
    void'($urandom(64918));
    rst    = 1'b1;
    errors = 0;
    checks = 0;
    cycles = 0;
    slot   = 32'h100;
    test_reset();
    test_alu();
    test_control();
    test_memory();
    test_csr();
    test_trap();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
common/rv_pkg.sv
decode/instr_decoder.sv
exec/alu.sv
exec/exec_ctrl.sv
rtl/reg_file.sv
rtl/csr_file.sv
rtl/bus_master.sv
rtl/core_top.sv
test/tb_mem.sv
test/tb_core.sv
